//--- ldvio_ctrl.sv
`timescale 1ns/10ps

// table controller
// idle: violation strobes become train writes in the same cycle
// flush: one clear per cycle over every index, busy high meanwhile
module ldvio_ctrl #(
  parameter int DEPTH = 16,
  parameter int INDEX = 4,
  parameter int TAG_W = 8,
  parameter int PC_W  = 32
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            viol_i,    // one-cycle strobe from commit
  input  logic [PC_W-1:0] viol_pc_i, // pc of the violating load
  input  logic            flush_i,   // start a table sweep
  output logic            busy_o,    // reports are dropped while high
  ldvio_wr_if.ctrl        wr
);

  localparam int IDX_LO = ldvio_pkg::PC_OFS;
  localparam int TAG_LO = IDX_LO + INDEX;
  localparam logic [INDEX-1:0] LAST_IDX = INDEX'(DEPTH - 1); // final index of a sweep

  ldvio_pkg::ctrl_state_e state_q;
  ldvio_pkg::ctrl_state_e state_d;
  logic [INDEX-1:0]       flush_idx_q; // index cleared this cycle
  logic [INDEX-1:0]       flush_idx_d;
  logic [INDEX-1:0]       viol_idx;    // index field of the training pc
  logic [TAG_W-1:0]       viol_tag;    // tag field of the training pc

  // same pc split as the lookup
  assign viol_idx = viol_pc_i[IDX_LO +: INDEX];
  assign viol_tag = viol_pc_i[TAG_LO +: TAG_W];

  assign busy_o = (state_q == ldvio_pkg::FLUSH);

  // next state and write port
  always_comb
  begin
    state_d     = state_q;
    flush_idx_d = flush_idx_q;
    wr.we       = 1'b0;
    wr.op       = ldvio_pkg::WR_TRAIN;
    wr.addr     = viol_idx;
    wr.tag      = viol_tag; // tag is ignored on clears

    case (state_q)
      ldvio_pkg::IDLE:
      begin
        wr.we = viol_i; // train lands at the edge ending this cycle
        if (flush_i)
        begin
          state_d     = ldvio_pkg::FLUSH; // a train in this cycle still happens
          flush_idx_d = '0;
        end
      end

      ldvio_pkg::FLUSH:
      begin
        // violations and repeated flushes are dropped here
        wr.we       = 1'b1;
        wr.op       = ldvio_pkg::WR_CLEAR;
        wr.addr     = flush_idx_q;
        flush_idx_d = flush_idx_q + 1'b1;
        if (flush_idx_q == LAST_IDX)
        begin
          state_d     = ldvio_pkg::IDLE; // exactly DEPTH clears done
          flush_idx_d = '0;
        end
      end

      default:
      begin
        state_d     = ldvio_pkg::IDLE;
        flush_idx_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q     <= ldvio_pkg::IDLE;
      flush_idx_q <= '0;
    end
    else
    begin
      state_q     <= state_d;
      flush_idx_q <= flush_idx_d;
    end
  end

endmodule

//--- ldvio_lookup.sv
`timescale 1ns/10ps

// per-lane lookup, purely combinational
// splits each pc, addresses both rams, forms the wait prediction
module ldvio_lookup #(
  parameter int LANES = 2,
  parameter int INDEX = 4,
  parameter int TAG_W = 8,
  parameter int PC_W  = 32
) (
  input  logic [LANES-1:0]            lane_load_i, // lane carries a load
  input  logic [LANES-1:0][PC_W-1:0]  lane_pc_i,   // lane pc
  output logic [LANES-1:0][INDEX-1:0] rd_addr_o,   // to both rams
  input  logic [LANES-1:0]            rd_vld_i,    // from valid ram
  input  logic [LANES-1:0][TAG_W-1:0] rd_tag_i,    // from tag ram
  output logic [LANES-1:0]            predict_o    // 1 = wait for older stores
);

  localparam int IDX_LO = ldvio_pkg::PC_OFS;  // index sits above the word offset
  localparam int TAG_LO = IDX_LO + INDEX;      // tag sits above the index

  logic [LANES-1:0][TAG_W-1:0] lane_tag; // tag field of each lane pc
  logic [LANES-1:0]            tag_hit;  // stored tag equals lane tag

  genvar l;
  for (l = 0; l < LANES; l++)
  begin : g_lane
    // pc field split
    assign rd_addr_o[l] = lane_pc_i[l][IDX_LO +: INDEX];
    assign lane_tag[l]  = lane_pc_i[l][TAG_LO +: TAG_W];

    // partial tag compare, aliases with equal low bits still hit
    assign tag_hit[l] = (rd_tag_i[l] == lane_tag[l]);

    // load flag gates everything, non-loads never wait
    assign predict_o[l] = lane_load_i[l] & rd_vld_i[l] & tag_hit[l];
  end

endmodule

//--- ldvio_pkg.sv
package ldvio_pkg;

  // controller states, one bit is enough for two states
  typedef enum logic [0:0]
  {
    IDLE  = 1'b0, // normal operation, training allowed
    FLUSH = 1'b1  // sweeping the table, one entry per cycle
  } ctrl_state_e;

  // table write opcodes, decoded separately by each ram
  typedef enum logic [0:0]
  {
    WR_TRAIN = 1'b0, // set valid, store tag
    WR_CLEAR = 1'b1  // drop valid, tag left alone
  } wr_op_e;

  // the word offset sits below the index in every pc
  localparam int unsigned PC_OFS = 2;

endpackage

//--- ldvio_pred_assert.sv
`timescale 1ns/10ps

// controller checks, bound into ldvio_ctrl
module ldvio_pred_assert #(
  parameter int DEPTH = 16
) (
  input logic                   clk,
  input logic                   reset,
  input ldvio_pkg::ctrl_state_e state_i,
  input logic                   viol_i,
  input logic                   busy_i,
  input logic                   we_i,
  input ldvio_pkg::wr_op_e      op_i
);

  int unsigned busy_run; // consecutive busy cycles so far

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy_run <= 0;
    end
    else if (busy_i)
    begin
      busy_run <= busy_run + 1;
    end
    else
    begin
      busy_run <= 0;
    end
  end

  // idle writes are exactly the training strobes
  a_idle_we: assert property (
    @(posedge clk) disable iff (reset)
    (state_i == ldvio_pkg::IDLE) |-> (we_i == viol_i)
  ) else $error("table write strobe differs from viol_i in IDLE");

  // the sweep never trains
  a_flush_clear: assert property (
    @(posedge clk) disable iff (reset)
    ((state_i == ldvio_pkg::FLUSH) && we_i) |-> (op_i == ldvio_pkg::WR_CLEAR)
  ) else $error("non-clear table write during FLUSH");

  // one sweep covers every entry once
  a_busy_window: assert property (
    @(posedge clk) disable iff (reset)
    $fell(busy_i) |-> (busy_run == DEPTH)
  ) else $error("busy_o was not high for exactly DEPTH cycles");

endmodule

bind ldvio_ctrl ldvio_pred_assert #(
  .DEPTH (DEPTH)
) assert0 (
  .clk     (clk),
  .reset   (reset),
  .state_i (state_q),
  .viol_i  (viol_i),
  .busy_i  (busy_o),
  .we_i    (wr.we),
  .op_i    (wr.op)
);

//--- ldvio_pred_top.sv
`timescale 1ns/10ps

// load-violation predictor, two-wide dispatch by default
// lookup is same-cycle, training and flush come from commit
module ldvio_pred_top #(
  parameter int LANES = 2,  // dispatch lanes
  parameter int DEPTH = 16, // table entries
  parameter int INDEX = 4,  // log2 of DEPTH
  parameter int TAG_W = 8,  // partial tag bits
  parameter int PC_W  = 32
) (
  input  logic                       clk,
  input  logic                       reset,
  // dispatch side
  input  logic [LANES-1:0]           lane_load_i,
  input  logic [LANES-1:0][PC_W-1:0] lane_pc_i,
  output logic [LANES-1:0]           predict_o,
  // commit side
  input  logic                       viol_i,
  input  logic [PC_W-1:0]            viol_pc_i,
  input  logic                       flush_i,
  output logic                       busy_o
);

  logic [LANES-1:0][INDEX-1:0] rd_addr; // lookup to both rams
  logic [LANES-1:0]            rd_vld;  // valid ram to lookup
  logic [LANES-1:0][TAG_W-1:0] rd_tag;  // tag ram to lookup

  // shared table write port
  ldvio_wr_if #(
    .INDEX (INDEX),
    .TAG_W (TAG_W)
  ) wr_bus ();

  ldvio_ctrl #(
    .DEPTH (DEPTH),
    .INDEX (INDEX),
    .TAG_W (TAG_W),
    .PC_W  (PC_W)
  ) ctrl0 (
    .clk       (clk),
    .reset     (reset),
    .viol_i    (viol_i),
    .viol_pc_i (viol_pc_i),
    .flush_i   (flush_i),
    .busy_o    (busy_o),
    .wr        (wr_bus.ctrl)
  );

  ldvio_vld_ram #(
    .LANES (LANES),
    .DEPTH (DEPTH),
    .INDEX (INDEX)
  ) vld_ram0 (
    .clk       (clk),
    .reset     (reset),
    .rd_addr_i (rd_addr),
    .rd_vld_o  (rd_vld),
    .wr        (wr_bus.ram)
  );

  // tag ram has no reset input
  ldvio_tag_ram #(
    .LANES (LANES),
    .DEPTH (DEPTH),
    .INDEX (INDEX),
    .TAG_W (TAG_W)
  ) tag_ram0 (
    .clk       (clk),
    .rd_addr_i (rd_addr),
    .rd_tag_o  (rd_tag),
    .wr        (wr_bus.ram)
  );

  ldvio_lookup #(
    .LANES (LANES),
    .INDEX (INDEX),
    .TAG_W (TAG_W),
    .PC_W  (PC_W)
  ) lookup0 (
    .lane_load_i (lane_load_i),
    .lane_pc_i   (lane_pc_i),
    .rd_addr_o   (rd_addr),
    .rd_vld_i    (rd_vld),
    .rd_tag_i    (rd_tag),
    .predict_o   (predict_o)
  );

endmodule

//--- ldvio_tag_ram.sv
`timescale 1ns/10ps

// partial pc tag per table entry
// LANES combinational reads, one synchronous write
module ldvio_tag_ram #(
  parameter int LANES = 2,
  parameter int DEPTH = 16,
  parameter int INDEX = 4,
  parameter int TAG_W = 8
) (
  input  logic                        clk,
  input  logic [LANES-1:0][INDEX-1:0] rd_addr_i, // one index per lane
  output logic [LANES-1:0][TAG_W-1:0] rd_tag_o,  // stored tag per lane
  ldvio_wr_if.ram                     wr
);

  logic [TAG_W-1:0] tag_mem [DEPTH]; // contents only matter where valid is set

  // parallel reads
  genvar l;
  for (l = 0; l < LANES; l++)
  begin : g_rd
    assign rd_tag_o[l] = tag_mem[rd_addr_i[l]];
  end

  // only a train write changes the tag
  // a clear leaves the old tag behind, masked by the valid ram
  always_ff @(posedge clk)
  begin
    if (wr.we && (wr.op == ldvio_pkg::WR_TRAIN))
    begin
      tag_mem[wr.addr] <= wr.tag; // alias training overwrites here
    end
  end

endmodule

//--- ldvio_vld_ram.sv
`timescale 1ns/10ps

// valid bit per table entry
// LANES combinational reads, one synchronous write, cleared on reset
module ldvio_vld_ram #(
  parameter int LANES = 2,
  parameter int DEPTH = 16,
  parameter int INDEX = 4
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [LANES-1:0][INDEX-1:0] rd_addr_i, // one index per dispatch lane
  output logic [LANES-1:0]            rd_vld_o,  // valid bit per lane
  ldvio_wr_if.ram                     wr
);

  // small enough to stay in flops
  logic [DEPTH-1:0] vld_q;

  // parallel reads, no latency
  genvar l;
  for (l = 0; l < LANES; l++)
  begin : g_rd
    assign rd_vld_o[l] = vld_q[rd_addr_i[l]];
  end

  // train sets the bit, clear drops it
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      vld_q <= '0; // empty table after reset
    end
    else if (wr.we)
    begin
      case (wr.op)
        ldvio_pkg::WR_TRAIN: vld_q[wr.addr] <= 1'b1;
        ldvio_pkg::WR_CLEAR: vld_q[wr.addr] <= 1'b0;
        default:             vld_q[wr.addr] <= 1'b0; // unknown op treated as clear
      endcase
    end
  end

  // a write and a read to the same index in one cycle
  // the read returns the old bit, the new one shows a cycle later

endmodule

//--- ldvio_wr_if.sv
`timescale 1ns/10ps

// single write port of the predictor table
// one driver (the controller), two receivers (valid ram, tag ram)
interface ldvio_wr_if #(
  parameter int INDEX = 4,
  parameter int TAG_W = 8
);

  logic               we;   // write strobe, acts on the rising edge
  ldvio_pkg::wr_op_e  op;   // what each ram stores
  logic [INDEX-1:0]   addr; // table index
  logic [TAG_W-1:0]   tag;  // partial pc tag, only used on train

  // controller side
  modport ctrl
  (
    output we,
    output op,
    output addr,
    output tag
  );

  // ram side, both rams see the same write
  modport ram
  (
    input we,
    input op,
    input addr,
    input tag
  );

endinterface

//--- project.f
ldvio_pkg.sv
ldvio_wr_if.sv
ldvio_vld_ram.sv
ldvio_tag_ram.sv
ldvio_lookup.sv
ldvio_ctrl.sv
ldvio_pred_top.sv
ldvio_pred_assert.sv
tb_ldvio_pred.sv

//--- run.sh
#!/bin/sh
# build and run the predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ldvio_pred -f project.f -o sim_ldvio

# tee keeps the output visible, the log decides the result
./obj_dir/sim_ldvio 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

//--- tb_ldvio_pred.sv
`timescale 1ns/10ps

// testbench for the load-violation predictor, default two lanes
module tb_ldvio_pred;

  localparam int LANES  = 2;
  localparam int DEPTH  = 16;
  localparam int INDEX  = 4;
  localparam int TAG_W  = 8;
  localparam int PC_W   = 32;
  localparam int PC_OFS = 2;            // word offset below the index
  localparam int TIMEOUT_CYCLES = 2000; // tests need about 400

  localparam logic [PC_W-1:0] PC_A = 32'h0000_1234; // index 13, tag 8'h48
  localparam logic [PC_W-1:0] PC_B = 32'h0000_1634; // alias of A, tag 8'h58
  localparam logic [PC_W-1:0] PC_C = 32'h0000_0108; // index 2
  localparam logic [PC_W-1:0] PC_D = 32'h0000_3324; // index 9
  localparam logic [PC_W-1:0] PC_E = 32'h0000_5550; // index 4

  logic                       clk;
  logic                       reset;
  logic [LANES-1:0]           lane_load;
  logic [LANES-1:0][PC_W-1:0] lane_pc;
  logic [LANES-1:0]           predict;
  logic                       viol;
  logic [PC_W-1:0]            viol_pc;
  logic                       flush;
  logic                       busy;

  // reference table
  logic             m_vld [DEPTH];
  logic [TAG_W-1:0] m_tag [DEPTH];
  logic             m_busy;      // model sweep in progress
  int               m_flush_idx; // next index the sweep clears

  logic [31:0] rng_state;
  int          err_count;
  int          cycle_count;

  ldvio_pred_top dut0 (
    .clk         (clk),
    .reset       (reset),
    .lane_load_i (lane_load),
    .lane_pc_i   (lane_pc),
    .predict_o   (predict),
    .viol_i      (viol),
    .viol_pc_i   (viol_pc),
    .flush_i     (flush),
    .busy_o      (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223; // classic lcg constants
    return rng_state;
  endfunction

  function automatic logic [INDEX-1:0] pc_index(input logic [PC_W-1:0] pc);
    return pc[PC_OFS +: INDEX];
  endfunction

  function automatic logic [TAG_W-1:0] pc_tag(input logic [PC_W-1:0] pc);
    return pc[PC_OFS+INDEX +: TAG_W];
  endfunction

  // wait only if load, valid entry and matching partial tag
  function automatic logic [LANES-1:0] model_predict(input logic [LANES-1:0] load,
                                                     input logic [LANES-1:0][PC_W-1:0] pcs);
    logic [LANES-1:0] p;
    for (int l = 0; l < LANES; l++)
    begin
      p[l] = load[l] && m_vld[pc_index(pcs[l])] && (m_tag[pc_index(pcs[l])] == pc_tag(pcs[l]));
    end
    return p;
  endfunction

  // state after the edge that ends the current cycle
  task automatic update_model(input logic v, input logic [PC_W-1:0] vpc, input logic f);
    if (!m_busy)
    begin
      if (v)
      begin
        m_vld[pc_index(vpc)] = 1'b1;
        m_tag[pc_index(vpc)] = pc_tag(vpc); // alias overwrites
      end
      if (f)
      begin
        m_busy      = 1'b1;
        m_flush_idx = 0;
      end
    end
    else
    begin
      m_vld[m_flush_idx] = 1'b0; // reports and flushes dropped here
      if (m_flush_idx == DEPTH - 1)
        m_busy = 1'b0;
      m_flush_idx++;
    end
  endtask

  task automatic check_predict(input logic [LANES-1:0] expected);
    if (predict !== expected)
    begin
      err_count++;
      $display("[ERROR] %0t: predict_o expected %b, got %b", $time, expected, predict);
      $display("ERRORS FOUND");
      $fatal(1, "predict_o mismatch");
    end
  endtask

  task automatic check_busy(input logic expected);
    if (busy !== expected)
    begin
      err_count++;
      $display("[ERROR] %0t: busy_o expected %b, got %b", $time, expected, busy);
      $display("ERRORS FOUND");
      $fatal(1, "busy_o mismatch");
    end
  endtask

  // one cycle of stimulus, compared with the model before the next edge
  task automatic drive_cycle(input logic [LANES-1:0] load, input logic [PC_W-1:0] pc0,
                             input logic [PC_W-1:0] pc1, input logic v,
                             input logic [PC_W-1:0] vpc, input logic f);
    @(posedge clk);
    lane_load  <= load;
    lane_pc[0] <= pc0;
    lane_pc[1] <= pc1;
    viol       <= v;
    viol_pc    <= vpc;
    flush      <= f;
    @(negedge clk); // lookup settled
    check_predict(model_predict(load, {pc1, pc0}));
    check_busy(m_busy);
    update_model(v, vpc, f);
  endtask

  task automatic test_reset();
    for (int i = 0; i < 8; i++)
    begin
      drive_cycle(2'b11, next_random(), next_random(), 1'b0, '0, 1'b0);
      check_predict(2'b00); // empty table
      check_busy(1'b0);
    end
  endtask

  task automatic test_train();
    drive_cycle(2'b11, PC_A, PC_A, 1'b1, PC_A, 1'b0);
    check_predict(2'b00); // strobe cycle still sees the old entry
    drive_cycle(2'b11, PC_A, PC_A, 1'b0, '0, 1'b0);
    check_predict(2'b11);
    drive_cycle(2'b01, PC_A, PC_A, 1'b0, '0, 1'b0);
    check_predict(2'b01);
    drive_cycle(2'b10, PC_A, PC_A, 1'b0, '0, 1'b0);
    check_predict(2'b10);
    drive_cycle(2'b11, PC_A, PC_C, 1'b0, '0, 1'b0);
    check_predict(2'b01); // C never trained
  endtask

  task automatic test_alias();
    drive_cycle(2'b11, PC_B, PC_A, 1'b0, '0, 1'b0);
    check_predict(2'b10); // tag differs, B misses
    drive_cycle(2'b11, PC_A, PC_B, 1'b1, PC_B, 1'b0);
    check_predict(2'b01);
    drive_cycle(2'b11, PC_A, PC_B, 1'b0, '0, 1'b0);
    check_predict(2'b10); // B replaced A
  endtask

  task automatic test_flush();
    drive_cycle(2'b00, PC_A, PC_A, 1'b1, PC_A, 1'b0);
    drive_cycle(2'b00, PC_A, PC_A, 1'b1, PC_C, 1'b0);
    drive_cycle(2'b11, PC_A, PC_C, 1'b1, PC_D, 1'b1); // train D with the pulse
    check_busy(1'b0);
    for (int i = 0; i < DEPTH; i++)
    begin
      // E strobe comes after index 4 was already swept
      drive_cycle(2'b11, PC_A, PC_D, (i == 10), PC_E, (i == 6));
      if (i == 0)
        check_predict(2'b11); // D landed, nothing swept yet
      check_busy(1'b1);
    end
    drive_cycle(2'b11, PC_A, PC_D, 1'b0, '0, 1'b0);
    check_busy(1'b0); // exactly DEPTH busy cycles
    check_predict(2'b00);
    drive_cycle(2'b11, PC_C, PC_E, 1'b0, '0, 1'b0);
    check_predict(2'b00); // E strobe was dropped
  endtask

  task automatic test_random();
    logic [31:0]     r;
    logic [PC_W-1:0] pool [8];
    pool = '{PC_A, PC_B, PC_C, PC_D, PC_E, 32'h0000_7f3c, 32'h0001_0000, 32'h0000_0000};
    for (int i = 0; i < 200; i++)
    begin
      r = next_random();
      drive_cycle(r[1:0], pool[r[4:2]], pool[r[7:5]], (r[10:8] == 3'd0),
                  pool[r[13:11]], (r[20:16] == 5'd0)); // rare flushes
    end
  endtask

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  end

  initial
  begin
    reset     = 1'b1;
    lane_load = '0;
    lane_pc   = '0;
    viol      = 1'b0;
    viol_pc   = '0;
    flush     = 1'b0;
    rng_state = 32'hb833700e;
    err_count = 0;
    m_busy    = 1'b0;
    m_flush_idx = 0;
    for (int i = 0; i < DEPTH; i++)
    begin
      m_vld[i] = 1'b0;
      m_tag[i] = '0;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    test_reset();
    test_train();
    test_alias();
    test_flush();
    test_random();
    if (err_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule
